// File: Bender.yml
package:
  name: wr_req_concentrator

sources:
  - include_dirs:
      - logic
    files:
      - logic/arb_pkg.sv
      - logic/req_pkg.sv
      - logic/sync_fifo.sv
      - logic/rr_arbiter.sv
      - logic/burst_read_sequencer.sv
      - logic/grant_select.sv
      - logic/wr_req_concentrator.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/wr_req_concentrator_tb.sv

// File: logic/arb_pkg.sv
`default_nettype none

`include "wr_req_macros.svh"

package arb_pkg;

  // one bit per client port
  typedef logic [`WRQ_PORTS-1:0] port_vec_t;

  typedef logic [$clog2(`WRQ_PORTS)-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: logic/burst_read_sequencer.sv
`default_nettype none

`include "wr_req_macros.svh"

module burst_read_sequencer (
  input  logic              clk,
  input  logic              rst_reg,
  input  arb_pkg::port_vec_t grant,
  input  logic              grant_valid,
  output arb_pkg::port_vec_t fifo_re
);

  localparam int BEAT_BITS = $clog2(`WRQ_BURST_LEN);
  localparam logic [BEAT_BITS-1:0] BEAT_LAST = BEAT_BITS'(`WRQ_BURST_LEN - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BURST,
    S_COOL1,
    S_COOL2
  } state_t;

  state_t state;
  logic [BEAT_BITS-1:0] beat;

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      state <= S_IDLE;
      beat <= '0;
      fifo_re <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (grant_valid) begin
            fifo_re <= grant;
            beat <= '0;
            state <= S_BURST;
          end
        end
        S_BURST: begin
          if (beat == BEAT_LAST) begin
            beat <= '0;
            // a new port chains in with no gap, the same port has stale counts
            if (grant_valid && grant != fifo_re) begin
              fifo_re <= grant;
            end else begin
              fifo_re <= '0;
              state <= S_COOL1;
            end
          end else begin
            beat <= beat + 1'b1;
          end
        end
        S_COOL1: begin
          state <= S_COOL2; // lets the drained FIFO's count settle
        end
        S_COOL2: begin
          state <= S_IDLE;
        end
        default: begin
          fifo_re <= '0;
          state <= S_IDLE;
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst_reg) $onehot0(fifo_re))
    else $error("burst_read_sequencer: more than one port read");

endmodule

`default_nettype wire

// File: logic/grant_select.sv
`default_nettype none

`include "wr_req_macros.svh"

module grant_select (
  input  logic               clk,
  input  logic               rst_reg,
  input  arb_pkg::port_vec_t  fifo_valid,
  input  req_pkg::req_bus_t   fifo_dout,
  output logic               word_valid,
  output req_pkg::req_word_t  word
);

  import req_pkg::*;

  req_word_t sel_word;

  // at most one FIFO is valid, so an OR merge picks its word
  always_comb begin
    sel_word = '0;
    for (int i = 0; i < `WRQ_PORTS; i++) begin
      if (fifo_valid[i]) begin
        sel_word = sel_word | fifo_dout[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= |fifo_valid;
    end
  end

  always_ff @(posedge clk) begin
    word <= sel_word;
  end

  // holds only while the sequencer reads a single FIFO at a time
  assert property (@(posedge clk) disable iff (rst_reg) $onehot0(fifo_valid))
    else $error("grant_select: several FIFOs valid at once");

endmodule

`default_nettype wire

// File: logic/req_pkg.sv
`default_nettype none

`include "wr_req_macros.svh"

package req_pkg;

  // contents are opaque to the concentrator
  typedef logic [`WRQ_DATA_WIDTH-1:0] req_word_t;

  // port 0 sits in the low word
  typedef logic [`WRQ_PORTS-1:0][`WRQ_DATA_WIDTH-1:0] req_bus_t;

endpackage

`default_nettype wire

// File: logic/rr_arbiter.sv
`default_nettype none

`include "wr_req_macros.svh"

module rr_arbiter (
  input  logic              clk,
  input  logic              rst_reg,
  input  arb_pkg::port_vec_t request,
  output arb_pkg::port_vec_t grant,
  output logic              grant_valid
);

  import arb_pkg::*;

  localparam int HOLD_BITS = $clog2(`WRQ_BURST_LEN + 1);

  port_idx_t ptr;
  port_idx_t last;
  port_idx_t grant_idx;
  logic [HOLD_BITS-1:0] hold;
  logic [1:0] cool;
  logic taken;

  assign grant_valid = |request;
  assign last = ptr - 1'b1;

  // first requester at or after the pointer
  always_comb begin
    port_idx_t idx;
    logic found;
    found = 1'b0;
    grant = '0;
    grant_idx = '0;
    for (int i = 0; i < `WRQ_PORTS; i++) begin
      idx = ptr + port_idx_t'(i);
      if (request[idx] && !found) begin
        found = 1'b1;
        grant[idx] = 1'b1;
        grant_idx = idx;
      end
    end
  end

  // Hold and cool track the sequencer's burst slots, so the pointer only moves
  // on grants that actually start a burst
  always_comb begin
    taken = 1'b0;
    if (grant_valid && cool == 2'd0) begin
      if (hold == '0) begin
        taken = 1'b1; // sequencer is idle
      end else if (hold == HOLD_BITS'(1)) begin
        taken = (grant_idx != last); // final beat only chains to another port
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      ptr <= '0;
      hold <= '0;
      cool <= 2'd0;
    end else if (taken) begin
      ptr <= grant_idx + 1'b1;
      hold <= HOLD_BITS'(`WRQ_BURST_LEN);
    end else if (cool != 2'd0) begin
      cool <= cool - 1'b1;
    end else if (hold == HOLD_BITS'(1)) begin
      hold <= '0;
      cool <= 2'd2; // matches the two cool-down states
    end else if (hold != '0) begin
      hold <= hold - 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst_reg) grant_valid |-> $onehot(grant))
    else $error("rr_arbiter: grant not one-hot");

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int DEPTH_BITS = 4,
  parameter int AFULL_THRESHOLD = 8,
  parameter int AEMPTY_THRESHOLD = 4
) (
  input  logic                clk,
  input  logic                rst_reg,
  input  logic                we,
  input  req_pkg::req_word_t  din,
  input  logic                re,
  output logic                valid,
  output req_pkg::req_word_t  dout,
  output logic [DEPTH_BITS:0] count,
  output logic                empty,
  output logic                full,
  output logic                almostfull,
  output logic                almostempty
);

  import req_pkg::*;

  localparam logic [DEPTH_BITS:0] DEPTH = {1'b1, {DEPTH_BITS{1'b0}}};
  localparam logic [DEPTH_BITS:0] AFULL_LVL = AFULL_THRESHOLD[DEPTH_BITS:0];
  localparam logic [DEPTH_BITS:0] AEMPTY_LVL = AEMPTY_THRESHOLD[DEPTH_BITS:0];

  req_word_t mem [0:(1 << DEPTH_BITS)-1];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign do_wr = we & ~full;
  assign do_rd = re & ~empty;

  // flags are decoded from the registered count
  assign empty = (count == '0);
  assign full = (count == DEPTH);
  assign almostfull = (count >= AFULL_LVL);
  assign almostempty = (count < AEMPTY_LVL);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= do_rd; // dout lands one cycle after the read strobe
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  // upstream pacing must keep these from ever happening
  assert property (@(posedge clk) disable iff (rst_reg) !(we && full))
    else $error("sync_fifo: write while full");

  assert property (@(posedge clk) disable iff (rst_reg) !(re && empty))
    else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: logic/wr_req_concentrator.sv
`default_nettype none

`include "wr_req_macros.svh"

module wr_req_concentrator (
  input  logic               clk,
  input  logic               rst_reg,
  input  arb_pkg::port_vec_t  req_wr_en_in,
  input  req_pkg::req_bus_t   req_wr_data_in,
  output arb_pkg::port_vec_t  req_wr_available_in,
  input  logic               req_wr_available_out,
  output logic               req_wr_en_out,
  output req_pkg::req_word_t  req_wr_data_out
);

  import arb_pkg::*;
  import req_pkg::*;

  port_vec_t in_we;
  req_bus_t in_din;
  port_vec_t in_re;
  port_vec_t in_valid;
  req_bus_t in_dout;
  port_vec_t in_afull;
  port_vec_t in_aempty;

  port_vec_t arb_request;
  port_vec_t arb_grant;
  logic arb_grant_valid;

  logic sel_valid;
  req_word_t sel_word;

  logic out_we;
  req_word_t out_din;
  logic out_re;
  logic out_valid;
  req_word_t out_dout;
  logic out_empty;
  logic out_afull;
  logic out_aempty;

  for (genvar i = 0; i < `WRQ_PORTS; i++) begin : gen_in_fifos
    sync_fifo #(
      .DEPTH_BITS(`WRQ_IN_DEPTH_BITS),
      .AFULL_THRESHOLD(`WRQ_IN_AFULL),
      .AEMPTY_THRESHOLD(`WRQ_IN_AEMPTY)
    ) in_fifo (
      .clk(clk),
      .rst_reg(rst_reg),
      .we(in_we[i]),
      .din(in_din[i]),
      .re(in_re[i]),
      .valid(in_valid[i]),
      .dout(in_dout[i]),
      .count(),
      .empty(),
      .full(),
      .almostfull(in_afull[i]),
      .almostempty(in_aempty[i])
    );
  end

  // a port competes once it holds a burst and the output side has room
  assign arb_request = ~in_aempty & {`WRQ_PORTS{~out_afull}};

  rr_arbiter arbiter (
    .clk(clk),
    .rst_reg(rst_reg),
    .request(arb_request),
    .grant(arb_grant),
    .grant_valid(arb_grant_valid)
  );

  burst_read_sequencer sequencer (
    .clk(clk),
    .rst_reg(rst_reg),
    .grant(arb_grant),
    .grant_valid(arb_grant_valid),
    .fifo_re(in_re)
  );

  grant_select select (
    .clk(clk),
    .rst_reg(rst_reg),
    .fifo_valid(in_valid),
    .fifo_dout(in_dout),
    .word_valid(sel_valid),
    .word(sel_word)
  );

  sync_fifo #(
    .DEPTH_BITS(`WRQ_OUT_DEPTH_BITS),
    .AFULL_THRESHOLD(`WRQ_OUT_AFULL),
    .AEMPTY_THRESHOLD(`WRQ_OUT_AEMPTY)
  ) out_fifo (
    .clk(clk),
    .rst_reg(rst_reg),
    .we(out_we),
    .din(out_din),
    .re(out_re),
    .valid(out_valid),
    .dout(out_dout),
    .count(),
    .empty(out_empty),
    .full(),
    .almostfull(out_afull),
    .almostempty(out_aempty)
  );

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      in_we <= '0;
      out_we <= 1'b0;
      out_re <= 1'b0;
      req_wr_en_out <= 1'b0;
      req_wr_available_in <= '0;
    end else begin
      in_we <= req_wr_en_in;
      out_we <= sel_valid;
      req_wr_en_out <= out_valid;
      req_wr_available_in <= ~in_afull; // trails the count by one cycle
      // near empty the read runs every other cycle, so a registered strobe
      // never reaches an empty FIFO
      if (out_aempty) begin
        out_re <= req_wr_available_out & ~out_empty & ~out_re;
      end else begin
        out_re <= req_wr_available_out;
      end
    end
  end

  always_ff @(posedge clk) begin
    in_din <= req_wr_data_in;
    out_din <= sel_word;
    req_wr_data_out <= out_dout;
  end

endmodule

`default_nettype wire

// File: logic/wr_req_macros.svh
`ifndef WR_REQ_MACROS_SVH
`define WR_REQ_MACROS_SVH

`define WRQ_DATA_WIDTH 32
`define WRQ_PORTS 8

`define WRQ_IN_DEPTH_BITS 4
`define WRQ_OUT_DEPTH_BITS 4

// both almost-full levels leave eight words of slack
`define WRQ_IN_AFULL ((1 << `WRQ_IN_DEPTH_BITS) - 8)
`define WRQ_OUT_AFULL ((1 << `WRQ_OUT_DEPTH_BITS) - 8)

`define WRQ_IN_AEMPTY 4 // a port below this cannot fill a burst
`define WRQ_OUT_AEMPTY 2

`define WRQ_BURST_LEN 4

`endif

// File: test/wr_req_concentrator_tb.sv
`default_nettype none

`include "wr_req_macros.svh"

module wr_req_concentrator_tb;

  import arb_pkg::*;
  import req_pkg::*;

  localparam int PORTS = `WRQ_PORTS;
  localparam int SEQ_BITS = `WRQ_DATA_WIDTH - 3;
  localparam int DRAIN_LIMIT = 3000;
  localparam int STEP_LIMIT = 300;

  logic clk;
  logic rst_reg;
  port_vec_t req_wr_en_in;
  req_bus_t req_wr_data_in;
  port_vec_t req_wr_available_in;
  logic req_wr_available_out;
  logic req_wr_en_out;
  req_word_t req_wr_data_out;

  logic [31:0] lfsr;
  int sent [PORTS];
  int exp_seq [PORTS];
  int wait_cnt [PORTS];
  int run_len;
  port_idx_t run_port;
  logic fair_on;
  int mismatches;
  int timeouts;

  port_idx_t out_port;
  logic [SEQ_BITS-1:0] out_seq;
  int exp_now;
  int sent_burst;
  int max_wait;

  wr_req_concentrator dut0 (
    .clk(clk),
    .rst_reg(rst_reg),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .req_wr_available_in(req_wr_available_in),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out)
  );

  always #20 clk = ~clk;

  // port index in the top three bits, sequence number below
  assign out_port = port_idx_t'(req_wr_data_out[`WRQ_DATA_WIDTH-1 -: 3]);
  assign out_seq = req_wr_data_out[SEQ_BITS-1:0];
  assign exp_now = exp_seq[out_port];
  assign sent_burst = sent[out_port] - (sent[out_port] % `WRQ_BURST_LEN); // whole bursts only

  always_comb begin
    max_wait = 0;
    for (int p = 0; p < PORTS; p++) begin
      if (wait_cnt[p] > max_wait) begin
        max_wait = wait_cnt[p];
      end
    end
  end

  always @(posedge clk) begin
    if (rst_reg) begin
      run_len <= 0;
      run_port <= '0;
      for (int p = 0; p < PORTS; p++) begin
        exp_seq[p] <= 0;
        wait_cnt[p] <= 0;
      end
    end else begin
      if (req_wr_en_out) begin
        exp_seq[out_port] <= exp_seq[out_port] + 1;
        if (run_len == 0 || run_len == `WRQ_BURST_LEN) begin
          run_port <= out_port;
          run_len <= 1;
        end else begin
          run_len <= run_len + 1;
        end
      end
      for (int p = 0; p < PORTS; p++) begin
        if (!fair_on) begin
          wait_cnt[p] <= 0;
        end else if (req_wr_en_out && out_seq[1:0] == 2'b00) begin
          wait_cnt[p] <= (port_idx_t'(p) == out_port) ? 0 : wait_cnt[p] + 1; // bursts of others
        end
      end
    end
  end

  assert property (@(posedge clk) rst_reg |=> (req_wr_available_in == '0 && !req_wr_en_out))
    else report_mismatch("control outputs not low after reset");
  assert property (@(posedge clk) $fell(rst_reg) |=> req_wr_available_in == '1)
    else report_mismatch("req_wr_available_in not all ones after reset");
  assert property (@(posedge clk) disable iff (rst_reg) req_wr_en_out |-> int'(out_seq) == exp_now)
    else report_mismatch("word out of order for its port");
  assert property (@(posedge clk) disable iff (rst_reg)
    req_wr_en_out |-> int'(out_seq) < sent_burst)
    else report_mismatch("word delivered before its burst was complete");
  assert property (@(posedge clk) disable iff (rst_reg)
    req_wr_en_out && run_len != 0 && run_len != `WRQ_BURST_LEN |->
      out_port == run_port && out_seq[1:0] == run_len[1:0])
    else report_mismatch("burst of four broken up");
  assert property (@(posedge clk) disable iff (rst_reg)
    req_wr_en_out && (run_len == 0 || run_len == `WRQ_BURST_LEN) |-> out_seq[1:0] == 2'b00)
    else report_mismatch("burst does not start on a four-word boundary");
  assert property (@(posedge clk) disable iff (rst_reg) fair_on |-> max_wait < PORTS)
    else report_mismatch("port waited more than seven bursts");
  // read strobe, FIFO valid and output register give three edges of delay
  assert property (@(posedge clk) disable iff (rst_reg)
    !req_wr_available_out |-> ##3 !req_wr_en_out)
    else report_mismatch("req_wr_en_out high under back-pressure");

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at time %0t while waiting for %s", $time, what);
  endtask

  // a port writes only while its available bit is high
  task automatic drive_cycle(input port_vec_t want, input logic avail_out);
    @(negedge clk);
    req_wr_available_out = avail_out;
    for (int p = 0; p < PORTS; p++) begin
      if (want[p] && req_wr_available_in[p]) begin
        req_wr_en_in[p] = 1'b1;
        req_wr_data_in[p] = {3'(p), SEQ_BITS'(sent[p])};
        sent[p]++;
      end else begin
        req_wr_en_in[p] = 1'b0;
      end
    end
  endtask

  function automatic logic all_delivered();
    for (int p = 0; p < PORTS; p++) begin
      if (exp_seq[p] != sent[p]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic top_up();
    port_vec_t want;
    int cycles;
    cycles = 0;
    do begin
      for (int p = 0; p < PORTS; p++) begin
        want[p] = (sent[p] % `WRQ_BURST_LEN) != 0;
      end
      drive_cycle(want, 1'b1);
      cycles++;
    end while (want != '0 && cycles < STEP_LIMIT);
    if (want != '0) begin
      report_timeout("ports to be topped up to whole bursts");
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    drive_cycle('0, 1'b1);
    while (!all_delivered() && cycles < DRAIN_LIMIT) begin
      drive_cycle('0, 1'b1);
      cycles++;
    end
    if (!all_delivered()) begin
      report_timeout("the output to drain");
    end
    for (int p = 0; p < PORTS; p++) begin
      assert (exp_seq[p] == sent[p] && sent[p] % `WRQ_BURST_LEN == 0)
        else report_mismatch($sformatf("port %0d delivered %0d of %0d", p, exp_seq[p], sent[p]));
    end
  endtask

  initial begin
    logic [31:0] bits;
    logic [31:0] gap;
    logic [31:0] low;
    int cycles;
    clk = 1'b0;
    rst_reg = 1'b1;
    req_wr_en_in = '0;
    req_wr_data_in = '0;
    req_wr_available_out = 1'b1;
    lfsr = 32'h4448;
    fair_on = 1'b0;
    mismatches = 0;
    timeouts = 0;
    for (int p = 0; p < PORTS; p++) begin
      sent[p] = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_reg = 1'b0;

    cycles = 0;
    while (req_wr_available_in != '1 && cycles < 20) begin
      drive_cycle('0, 1'b1);
      cycles++;
    end
    if (req_wr_available_in != '1) begin
      report_timeout("req_wr_available_in after reset");
    end

    repeat (3) drive_cycle(8'h20, 1'b1); // port 5 holds three words, less than a burst
    repeat (40) drive_cycle('0, 1'b1);
    drive_cycle(8'h20, 1'b1);
    wait_drain();

    for (int i = 0; i < 600; i++) begin
      draw_bits(PORTS, bits);
      draw_bits(2, gap);
      draw_bits(2, low);
      drive_cycle((gap == 0) ? port_vec_t'(0) : port_vec_t'(bits), low != 0);
    end
    top_up();
    wait_drain();

    fair_on = 1'b1; // every port loaded continuously
    repeat (400) drive_cycle('1, 1'b1);
    fair_on = 1'b0;
    top_up();
    wait_drain();

    repeat (40) drive_cycle('1, 1'b1); // output streaming before back-pressure starts
    cycles = 0;
    drive_cycle('1, 1'b0);
    while (req_wr_en_out && cycles < 20) begin
      drive_cycle('1, 1'b0);
      cycles++;
    end
    if (req_wr_en_out) begin
      report_timeout("req_wr_en_out to fall under back-pressure");
    end
    cycles = 0;
    while (req_wr_available_in != '0 && cycles < STEP_LIMIT) begin
      drive_cycle('1, 1'b0);
      cycles++;
    end
    if (req_wr_available_in != '0) begin
      report_timeout("req_wr_available_in to fall under back-pressure");
    end
    top_up();
    wait_drain();

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wr_req_concentrator.f
+incdir+logic
logic/arb_pkg.sv
logic/req_pkg.sv
logic/sync_fifo.sv
logic/rr_arbiter.sv
logic/burst_read_sequencer.sv
logic/grant_select.sv
logic/wr_req_concentrator.sv
test/wr_req_concentrator_tb.sv
